// File: sim.f
common/cpu_pkg.sv
core/fetch_stage.sv
core/decode_stage.sv
core/execute_stage.sv
core/memory_stage.sv
source/bus_arbiter.sv
source/cpu_top.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// File: Bender.yml
package:
  name: rv32_pipe

sources:
  - common/cpu_pkg.sv
  - core/fetch_stage.sv
  - core/decode_stage.sv
  - core/execute_stage.sv
  - core/memory_stage.sv
  - source/bus_arbiter.sv
  - source/cpu_top.sv
  - target: test
    files:
      - dv/cpu_checker.sv
      - dv/cpu_tb.sv

// File: dv/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

  localparam int num_tests = 8;
  localparam int mem_words = 128;
  localparam int data_base = 64;   // first data word
  localparam int data_words = 64;
  localparam int body_end = 60;    // word of the final addi x17
  localparam int timeout_cycles = 5000;

  logic            clk;
  logic            reset;
  wb_req_t         bus_req;
  wb_rsp_t         bus_rsp;
  logic            halted;
  logic [xlen-1:0] mem [mem_words];
  logic [31:0]     seed;
  int              chk_errors;
  int              passed;
  int              failed;
  logic            in_cycle;  // slave is counting wait states
  int              wait_left;
  logic            ack_next;
  logic [xlen-1:0] dat_next;

  cpu_top dut (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .halted  (halted)
  );

  cpu_checker chk (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .halted  (halted),
    .image   (mem),
    .errors  (chk_errors)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed >> 8; // low bits of an lcg are weak
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'd1 + 5'(lcg_next() % 5); // x1..x5 keeps dependencies dense
  endfunction

  function automatic logic [11:0] data_offset();
    return 12'(data_base * 4 + (lcg_next() % data_words) * 4);
  endfunction

  function automatic logic [31:0] r_type(input int op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [2:0] f3;
    case (op)
      2:       f3 = 3'd7; // and
      3:       f3 = 3'd6; // or
      4:       f3 = 3'd4; // xor
      5:       f3 = 3'd2; // slt
      default: f3 = 3'd0; // add, sub
    endcase
    return {1'b0, op == 1, 5'd0, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input int op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    logic [2:0] f3;
    case (op)
      1:       f3 = 3'd7;
      2:       f3 = 3'd6;
      3:       f3 = 3'd4;
      default: f3 = 3'd0; // addi
    endcase
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'd2, rd, 7'h03};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic bne, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 2'b00, bne, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic build_program();
    int         kind;
    int         op;
    int         tgt;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < 5; i++)
      mem[i] = i_type(0, 5'(i + 1), 5'd0, 12'(lcg_next())); // no register starts undefined
    for (int i = 5; i < body_end; i++) begin
      kind = lcg_next() % 16;
      op = lcg_next() % 6;
      rd = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      tgt = i + 1 + lcg_next() % 8;
      if (tgt > body_end)
        tgt = body_end;
      if (kind < 4)
        mem[i] = r_type(op, rd, rs1, rs2);
      else if (kind < 7)
        mem[i] = i_type(op % 4, rd, rs1, 12'(lcg_next()));
      else if (kind < 10)
        mem[i] = load_word(rd, data_offset());
      else if (kind < 13)
        mem[i] = s_type(rs2, data_offset());
      else if (kind < 15)
        mem[i] = b_type(op[0], rs1, rs2, 13'((tgt - i) * 4));
      else
        mem[i] = j_type(rd, 21'((tgt - i) * 4));
    end
    mem[body_end] = i_type(0, 5'd17, 5'd0, 12'd10);
    mem[body_end + 1] = 32'h0000_0073; // ecall
    mem[body_end + 2] = nop_instr;     // fetched behind the ecall
    mem[body_end + 3] = nop_instr;
    for (int i = data_base; i < mem_words; i++)
      mem[i] = lcg_next() ^ (seed << 8);
  endtask

  // wishbone slave with 0 to 3 random wait states
  always @(posedge clk) begin
    ack_next = 1'b0;
    dat_next = '0;
    if (reset)
      in_cycle = 1'b0;
    else if (bus_rsp.ack) begin
      if (bus_req.we)
        mem[bus_req.adr[8:2]] = bus_req.dat_w;
      in_cycle = 1'b0;
    end else if (bus_req.cyc && bus_req.stb) begin
      if (!in_cycle) begin
        in_cycle = 1'b1;
        wait_left = lcg_next() % 4;
      end
      if (wait_left == 0) begin
        ack_next = 1'b1;
        dat_next = mem[bus_req.adr[8:2]];
      end else
        wait_left--;
    end
    #1;
    bus_rsp.ack = ack_next;
    bus_rsp.dat_r = dat_next;
  end

  task automatic run_test(input int idx);
    int errs_before;
    int cycles;
    @(posedge clk);
    #1;
    reset = 1'b1;
    build_program();
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    errs_before = chk_errors;
    cycles = 0;
    while (!halted && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("test %0d failed: halted never rose within %0d cycles", idx, timeout_cycles);
      failed++;
    end else begin
      repeat (10) @(posedge clk); // bus must stay quiet after halted
      #1;
      if (chk_errors == errs_before) begin
        $display("test %0d passed after %0d cycles", idx, cycles);
        passed++;
      end else begin
        $display("test %0d failed with %0d errors", idx, chk_errors - errs_before);
        failed++;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    bus_rsp = '0;
    seed = 32'h02c50b13;
    passed = 0;
    failed = 0;
    in_cycle = 1'b0;
    wait_left = 0;
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    $display("%0d tests run, %0d passed, %0d failed", num_tests, passed, failed);
    if (failed == 0 && chk_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: dv/cpu_checker.sv
module cpu_checker import cpu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  wb_req_t         bus_req,
  input  wb_rsp_t         bus_rsp,
  input  logic            halted,
  input  logic [xlen-1:0] image [128],
  output int              errors
);

  typedef struct packed {
    logic [xlen-1:0] adr;
    logic [xlen-1:0] dat;
  } store_t;

  logic [xlen-1:0] cmem [128];   // model's own memory
  store_t          expected [$];
  int              store_idx;
  logic            model_halts;
  logic            prev_reset;
  logic            prev_halted;
  logic            bus_open;      // cycle on the bus not yet acked
  logic            first_pending;

  initial begin
    errors = 0;
    prev_reset = 1'b0;
    prev_halted = 1'b0;
    bus_open = 1'b0;
    first_pending = 1'b1;
  end

  task automatic report_mismatch(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  function automatic logic [xlen-1:0] alu(input logic [2:0] f3, input logic sub,
                                          input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    case (f3)
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd6:    return a | b;
      3'd7:    return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  // one instruction per step, stores collected in program order
  task automatic run_model();
    logic [xlen-1:0] x [32];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] ins;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] addr;
    int              steps;
    for (int i = 0; i < 32; i++)
      x[i] = '0;
    pc = reset_pc;
    model_halts = 1'b0;
    expected.delete();
    store_idx = 0;
    steps = 0;
    while (!model_halts && steps < 256) begin
      ins = cmem[pc[8:2]];
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      next_pc = pc + 32'd4;
      case (ins[6:0])
        7'h33: x[ins[11:7]] = alu(ins[14:12], ins[30], a, b);
        7'h13: x[ins[11:7]] = alu(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
        7'h03: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          x[ins[11:7]] = cmem[addr[8:2]];
        end
        7'h23: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          cmem[addr[8:2]] = b;
          expected.push_back('{adr: addr, dat: b});
        end
        7'h63: if ((a == b) != ins[12])
          next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        7'h6f: begin
          x[ins[11:7]] = pc + 32'd4; // link
          next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h73: model_halts = (x[halt_reg] == halt_code);
        default: ;
      endcase
      x[0] = '0;
      pc = next_pc;
      steps++;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 128; i++)
        cmem[i] = image[i];
      if (prev_reset && (bus_req.cyc !== 1'b0 || bus_req.stb !== 1'b0 || halted !== 1'b0))
        report_failure($sformatf("bus cycle or halted active during reset at time %0t", $time));
      bus_open = 1'b0;
      first_pending = 1'b1;
    end else begin
      if (prev_reset) begin
        run_model();
        if (bus_req.cyc !== 1'b0 || bus_req.stb !== 1'b0 || halted !== 1'b0)
          report_failure("a bus cycle or halted was already up in the first cycle after reset");
      end
      if (bus_req.cyc && !bus_open) begin // a new bus cycle starts
        if (first_pending && (bus_req.we || bus_req.adr != reset_pc))
          report_mismatch($sformatf("first bus cycle we=%0b adr %h, expected a read at %h",
                                    bus_req.we, bus_req.adr, reset_pc));
        if (halted)
          report_failure("a new bus cycle started after halted rose");
        first_pending = 1'b0;
      end
      if (bus_req.cyc && bus_req.we && bus_rsp.ack) begin
        if (expected.size() == 0)
          report_failure($sformatf("store of %h to %h came when no more stores were expected",
                                   bus_req.dat_w, bus_req.adr));
        else begin
          if (bus_req.adr !== expected[0].adr || bus_req.dat_w !== expected[0].dat)
            report_mismatch($sformatf("store %0d wrote %h to %h, expected %h to %h", store_idx,
                                      bus_req.dat_w, bus_req.adr, expected[0].dat,
                                      expected[0].adr));
          void'(expected.pop_front());
          store_idx++;
        end
      end
      if (halted && !prev_halted && expected.size() != 0)
        report_failure($sformatf("halted after %0d stores while %0d more were expected",
                                 store_idx, expected.size()));
      bus_open = bus_req.cyc && !bus_rsp.ack;
    end
    prev_reset = reset;
    prev_halted = halted;
  end

endmodule

// File: source/cpu_top.sv
module cpu_top import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  output wb_req_t bus_req,
  input  wb_rsp_t bus_rsp,
  output logic    halted
);

  wb_req_t         instr_req;
  wb_req_t         data_req;
  wb_rsp_t         instr_rsp;
  wb_rsp_t         data_rsp;
  logic            advance;
  logic            stall;
  logic            redirect;
  logic [xlen-1:0] target;
  logic            mem_busy;
  if_id_t          if_id;
  id_ex_t          id_ex;
  ex_mem_t         ex_mem;
  mem_wb_t         mem_wb;

  fetch_stage u_fetch (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .target    (target),
    .mem_busy  (mem_busy),
    .halted    (halted),
    .instr_rsp (instr_rsp),
    .instr_req (instr_req),
    .advance   (advance),
    .if_id     (if_id)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .flush      (redirect),
    .if_id      (if_id),
    .id_ex_prev (id_ex),     // instruction now in execute
    .ex_mem     (ex_mem),
    .mem_wb     (mem_wb),
    .stall      (stall),
    .id_ex      (id_ex)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .advance  (advance),
    .id_ex    (id_ex),
    .mem_wb   (mem_wb),
    .redirect (redirect),
    .target   (target),
    .ex_mem   (ex_mem)
  );

  memory_stage u_memory (
    .clk      (clk),
    .reset    (reset),
    .advance  (advance),
    .ex_mem   (ex_mem),
    .data_rsp (data_rsp),
    .data_req (data_req),
    .mem_busy (mem_busy),
    .halted   (halted),
    .mem_wb   (mem_wb)
  );

  bus_arbiter u_arbiter (
    .clk       (clk),
    .reset     (reset),
    .instr_req (instr_req),
    .data_req  (data_req),
    .bus_rsp   (bus_rsp),
    .bus_req   (bus_req),
    .instr_rsp (instr_rsp),
    .data_rsp  (data_rsp)
  );

endmodule

// File: source/bus_arbiter.sv
module bus_arbiter import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  wb_req_t instr_req,
  input  wb_req_t data_req,
  input  wb_rsp_t bus_rsp,
  output wb_req_t bus_req,
  output wb_rsp_t instr_rsp,
  output wb_rsp_t data_rsp
);

  typedef enum logic [1:0] {grant_idle, grant_instr, grant_data} grant_e;

  grant_e state;
  grant_e grant;

  // a free bus is granted in the same cycle, data master first
  always_comb begin
    grant = state;
    if (state == grant_idle) begin
      if (data_req.cyc)
        grant = grant_data;
      else if (instr_req.cyc)
        grant = grant_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= grant_idle;
    else if (bus_rsp.ack)
      state <= grant_idle; // free again next cycle
    else
      state <= grant;
  end

  always_comb begin
    case (grant)
      grant_data:  bus_req = data_req;
      grant_instr: bus_req = instr_req;
      default:     bus_req = '0;
    endcase
    instr_rsp.ack = bus_rsp.ack && (grant == grant_instr);
    instr_rsp.dat_r = bus_rsp.dat_r;
    data_rsp.ack = bus_rsp.ack && (grant == grant_data);
    data_rsp.dat_r = bus_rsp.dat_r;
  end

endmodule

// File: core/memory_stage.sv
module memory_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    advance,
  input  ex_mem_t ex_mem,
  input  wb_rsp_t data_rsp,
  output wb_req_t data_req,
  output logic    mem_busy,
  output logic    halted,
  output mem_wb_t mem_wb
);

  logic            mem_op;
  logic            done;      // ack seen, waiting for the rest of the pipe
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] load_val;
  logic [xlen-1:0] wb_val;

  // nothing moves once halted, so this holds until reset
  assign halted = mem_wb.valid && mem_wb.halt;

  assign mem_op = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write) && !halted;
  assign mem_busy = mem_op && !done && !data_rsp.ack;

  always_comb begin
    data_req.cyc = mem_op && !done;
    data_req.stb = data_req.cyc;
    data_req.we = ex_mem.mem_write;
    data_req.adr = ex_mem.alu_result;
    data_req.dat_w = ex_mem.store_data;
  end

  always_ff @(posedge clk) begin
    if (reset)
      done <= 1'b0;
    else if (advance)
      done <= 1'b0;
    else if (data_rsp.ack)
      done <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (data_rsp.ack)
      load_data <= data_rsp.dat_r;
  end

  assign load_val = done ? load_data : data_rsp.dat_r; // ack may coincide with advance

  always_comb begin
    case (ex_mem.wb_sel)
      wb_mem:  wb_val = load_val;
      wb_pc4:  wb_val = ex_mem.pc4;
      default: wb_val = ex_mem.alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      mem_wb <= '0;
    else if (advance)
      mem_wb <= '{valid: ex_mem.valid, reg_write: ex_mem.reg_write, halt: ex_mem.halt,
                  rd: ex_mem.rd, wdata: wb_val};
  end

endmodule

// File: core/execute_stage.sv
module execute_stage import cpu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            advance,
  input  id_ex_t          id_ex,
  input  mem_wb_t         mem_wb,
  output logic            redirect,
  output logic [xlen-1:0] target,
  output ex_mem_t         ex_mem
);

  logic [xlen-1:0] ex_mem_val;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            equal;

  // jal links forward as pc+4, loads never reach here thanks to the stall
  assign ex_mem_val = (ex_mem.wb_sel == wb_pc4) ? ex_mem.pc4 : ex_mem.alu_result;

  function automatic logic [xlen-1:0] forward(input logic [reg_addr_w-1:0] idx,
                                              input logic [xlen-1:0] reg_val);
    if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == idx)
      return ex_mem_val; // youngest wins
    if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == idx)
      return mem_wb.wdata;
    return reg_val;
  endfunction

  always_comb begin
    rs1_val = forward(id_ex.rs1, id_ex.rs1_data);
    rs2_val = forward(id_ex.rs2, id_ex.rs2_data);
  end

  assign op_b = id_ex.alu_src ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub: alu_result = rs1_val - op_b;
      alu_and: alu_result = rs1_val & op_b;
      alu_or:  alu_result = rs1_val | op_b;
      alu_xor: alu_result = rs1_val ^ op_b;
      alu_slt: alu_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
      default: alu_result = rs1_val + op_b;
    endcase
  end

  assign equal = (rs1_val == rs2_val);

  // taken branch or jal, the two younger stages get flushed
  assign redirect = id_ex.valid &&
                    (id_ex.is_jal || (id_ex.is_branch && (equal != id_ex.is_bne)));
  assign target = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk) begin
    if (reset)
      ex_mem <= '0;
    else if (advance) begin
      ex_mem.valid <= id_ex.valid;
      ex_mem.reg_write <= id_ex.reg_write;
      ex_mem.mem_read <= id_ex.mem_read;
      ex_mem.mem_write <= id_ex.mem_write;
      ex_mem.wb_sel <= id_ex.wb_sel;
      ex_mem.halt <= id_ex.halt;
      ex_mem.rd <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= rs2_val;
      ex_mem.pc4 <= id_ex.pc4;
    end
  end

endmodule

// File: core/decode_stage.sv
module decode_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    advance,
  input  logic    flush,
  input  if_id_t  if_id,
  input  id_ex_t  id_ex_prev,
  input  ex_mem_t ex_mem,
  input  mem_wb_t mem_wb,
  output logic    stall,
  output id_ex_t  id_ex
);

  logic [xlen-1:0]       regs [32];
  logic [xlen-1:0]       instr;
  op_e                   opcode;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  is_ecall;
  logic [xlen-1:0]       x17_val;
  logic                  load_use;
  logic                  halt_hazard;
  id_ex_t                dec;

  assign instr = if_id.instr;
  assign opcode = op_e'(instr[6:0]);
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd = instr[11:7];

  function automatic alu_op_e funct_alu(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b111:  return alu_and;
      3'b110:  return alu_or;
      3'b100:  return alu_xor;
      3'b010:  return alu_slt;
      default: return sub ? alu_sub : alu_add;
    endcase
  endfunction

  // the write in mem_wb lands on the next advance, so bypass it here
  function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] idx);
    if (idx == '0)
      return '0;
    if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == idx)
      return mem_wb.wdata;
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (advance && mem_wb.valid && mem_wb.reg_write)
      regs[mem_wb.rd] <= mem_wb.wdata; // rd is never x0 here
  end

  // a7 for the halt check, ex_mem first
  always_comb begin
    if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == halt_reg)
      x17_val = (ex_mem.wb_sel == wb_pc4) ? ex_mem.pc4 : ex_mem.alu_result;
    else
      x17_val = read_reg(halt_reg);
  end

  always_comb begin
    dec = '0;
    dec.valid = 1'b1;
    dec.alu_op = alu_add;
    dec.wb_sel = wb_alu;
    dec.rs1 = rs1;
    dec.rs2 = rs2;
    dec.rd = rd;
    dec.rs1_data = read_reg(rs1);
    dec.rs2_data = read_reg(rs2);
    dec.pc = if_id.pc;
    dec.pc4 = if_id.pc4;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    is_ecall = 1'b0;
    case (opcode)
      op_reg: begin
        dec.reg_write = 1'b1;
        dec.alu_op = funct_alu(instr[14:12], instr[30]);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      op_imm: begin
        dec.reg_write = 1'b1;
        dec.alu_src = 1'b1;
        dec.alu_op = funct_alu(instr[14:12], 1'b0); // no subi
        dec.imm = {{20{instr[31]}}, instr[31:20]};
        uses_rs1 = 1'b1;
      end
      op_load: begin
        dec.reg_write = 1'b1;
        dec.mem_read = 1'b1;
        dec.alu_src = 1'b1;
        dec.wb_sel = wb_mem;
        dec.imm = {{20{instr[31]}}, instr[31:20]};
        uses_rs1 = 1'b1;
      end
      op_store: begin
        dec.mem_write = 1'b1;
        dec.alu_src = 1'b1;
        dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      op_branch: begin
        dec.is_branch = 1'b1;
        dec.is_bne = instr[12];
        dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      op_jal: begin
        dec.reg_write = 1'b1;
        dec.is_jal = 1'b1;
        dec.wb_sel = wb_pc4;
        dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      op_system: is_ecall = (instr[31:7] == '0);
      default: ; // anything else runs as a nop
    endcase
    if (rd == '0)
      dec.reg_write = 1'b0;
    dec.halt = is_ecall && (x17_val == halt_code);
  end

  assign load_use = id_ex_prev.valid && id_ex_prev.mem_read && id_ex_prev.reg_write &&
                    ((uses_rs1 && id_ex_prev.rd == rs1) || (uses_rs2 && id_ex_prev.rd == rs2));

  // a7 not yet computed: producer still in execute, or a load in memory
  assign halt_hazard = is_ecall &&
      ((id_ex_prev.valid && id_ex_prev.reg_write && id_ex_prev.rd == halt_reg) ||
       (ex_mem.valid && ex_mem.reg_write && ex_mem.mem_read && ex_mem.rd == halt_reg));

  assign stall = load_use || halt_hazard;

  always_ff @(posedge clk) begin
    if (reset)
      id_ex <= '0;
    else if (advance) begin
      if (stall || flush)
        id_ex <= '0; // bubble
      else
        id_ex <= dec;
    end
  end

endmodule

// File: core/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            redirect,
  input  logic [xlen-1:0] target,
  input  logic            mem_busy,
  input  logic            halted,
  input  wb_rsp_t         instr_rsp,
  output wb_req_t         instr_req,
  output logic            advance,
  output if_id_t          if_id
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] buf_instr;
  logic            buf_valid;
  logic            fetch_en;  // keeps the bus quiet right after reset

  assign advance = buf_valid && !mem_busy && !halted;

  // halted only rises on an advance, so no fetch is ever in flight then
  always_comb begin
    instr_req.cyc = fetch_en && !buf_valid && !halted;
    instr_req.stb = instr_req.cyc;
    instr_req.we = 1'b0;
    instr_req.adr = pc;
    instr_req.dat_w = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
      buf_valid <= 1'b0;
      fetch_en <= 1'b0;
      if_id <= '{instr: nop_instr, pc: '0, pc4: '0};
    end else begin
      fetch_en <= 1'b1;
      if (instr_rsp.ack) begin
        buf_valid <= 1'b1;
        buf_instr <= instr_rsp.dat_r;
      end
      if (advance) begin
        if (redirect) begin
          // buffered word is wrong path, drop it
          pc <= target;
          buf_valid <= 1'b0;
          if_id <= '{instr: nop_instr, pc: pc, pc4: pc + 32'd4};
        end else if (!stall) begin
          pc <= pc + 32'd4;
          buf_valid <= 1'b0;
          if_id <= '{instr: buf_instr, pc: pc, pc4: pc + 32'd4};
        end
      end
    end
  end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = '0;
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013; // addi x0,x0,0

  // ecall halts when a7 holds the exit code
  localparam logic [reg_addr_w-1:0] halt_reg = 5'd17;
  localparam logic [xlen-1:0] halt_code = 32'd10;

  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } op_e;

  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt} alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc4;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  alu_src;   // second operand is the immediate
    logic                  is_branch;
    logic                  is_bne;
    logic                  is_jal;
    logic                  halt;
    alu_op_e               alu_op;
    wb_sel_e               wb_sel;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       pc4;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    wb_sel_e               wb_sel;
    logic                  halt;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       alu_result; // also the data address
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       pc4;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic                  reg_write;
    logic                  halt;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       wdata;
  } mem_wb_t;

  // wishbone classic, word transfers only
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [xlen-1:0] adr;
    logic [xlen-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [xlen-1:0] dat_r;
  } wb_rsp_t;

endpackage
